// File: hw/riscv_settings.svh
`ifndef RISCV_SETTINGS_SVH
`define RISCV_SETTINGS_SVH

// Data and address width.
`define RV_XLEN      32

// Architectural integer registers.
`define RV_NREGS     32

// First fetch address after reset.
`define RV_RESET_PC  32'h0000_0000

// Word that test programs store to when they finish.
`define RV_DONE_ADDR 32'h0000_07fc

`endif

// File: hw/riscv_pkg.sv
`include "riscv_settings.svh"

package riscv_pkg;

  // Supported major opcodes.
  typedef enum logic [6:0] {
    OP_LUI    = 7'b0110111,
    OP_AUIPC  = 7'b0010111,
    OP_JAL    = 7'b1101111,
    OP_JALR   = 7'b1100111,
    OP_BRANCH = 7'b1100011,
    OP_LOAD   = 7'b0000011,
    OP_STORE  = 7'b0100011,
    OP_IMM    = 7'b0010011,
    OP_REG    = 7'b0110011
  } opcode_e;

  typedef enum logic [3:0] {
    ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND
  } alu_op_e;

  // ALU operand pairs.
  typedef enum logic [1:0] {
    RS1_RS2, RS1_IMM, PC_4, PC_IMM
  } src_sel_e;

  typedef enum logic [1:0] {
    FETCH, EXEC, MEM
  } core_state_e;

  typedef struct packed {
    alu_op_e    alu_op;
    src_sel_e   src_sel;
    logic       branch;
    logic       jump;
    logic       jalr;
    logic       load;
    logic       store;
    logic       reg_write;
    logic [2:0] func3;
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
  } ctrl_t;

  // Wishbone master outputs.
  typedef struct packed {
    logic                cyc;
    logic                stb;
    logic                we;
    logic [3:0]          sel;
    logic [`RV_XLEN-1:0] adr;
    logic [`RV_XLEN-1:0] dat;
  } wb_req_t;

endpackage

// File: hw/riscv_decoder.sv
`include "riscv_settings.svh"

module riscv_decoder import riscv_pkg::*; (
  input  logic [`RV_XLEN-1:0] instr,
  output ctrl_t               ctrl,
  output logic [`RV_XLEN-1:0] imm
);

  opcode_e             opcode;
  logic [`RV_XLEN-1:0] imm_i;
  logic [`RV_XLEN-1:0] imm_s;
  logic [`RV_XLEN-1:0] imm_b;
  logic [`RV_XLEN-1:0] imm_u;
  logic [`RV_XLEN-1:0] imm_j;

  // Bit 30 selects SUB only for register operands; SRA/SRAI use it in both groups.
  function automatic alu_op_e funct_to_alu(input logic [2:0] f3, input logic alt,
                                           input logic is_reg);
    alu_op_e op;
    case (f3)
      3'b000:  op = (is_reg && alt) ? SUB : ADD;
      3'b001:  op = SLL;
      3'b010:  op = SLT;
      3'b011:  op = SLTU;
      3'b100:  op = XOR;
      3'b101:  op = alt ? SRA : SRL;
      3'b110:  op = OR;
      default: op = AND;
    endcase
    return op;
  endfunction

  assign opcode = opcode_e'(instr[6:0]);

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb begin
    ctrl         = '0;
    ctrl.alu_op  = ADD;
    ctrl.src_sel = RS1_RS2;
    ctrl.func3   = instr[14:12];
    ctrl.rd      = instr[11:7];
    ctrl.rs1     = instr[19:15];
    ctrl.rs2     = instr[24:20];
    imm          = imm_i;
    case (opcode)
      OP_LUI: begin
        // x0 plus the upper immediate.
        ctrl.rs1       = 5'd0;
        ctrl.src_sel   = RS1_IMM;
        ctrl.reg_write = 1'b1;
        imm            = imm_u;
      end
      OP_AUIPC: begin
        ctrl.src_sel   = PC_IMM;
        ctrl.reg_write = 1'b1;
        imm            = imm_u;
      end
      OP_JAL: begin
        ctrl.src_sel   = PC_4;
        ctrl.jump      = 1'b1;
        ctrl.reg_write = 1'b1;
        imm            = imm_j;
      end
      OP_JALR: begin
        ctrl.src_sel   = PC_4;
        ctrl.jalr      = 1'b1;
        ctrl.reg_write = 1'b1;
      end
      OP_BRANCH: begin
        ctrl.alu_op = SUB;
        ctrl.branch = 1'b1;
        imm         = imm_b;
      end
      OP_LOAD: begin
        ctrl.src_sel   = RS1_IMM;
        ctrl.load      = 1'b1;
        ctrl.reg_write = 1'b1;
      end
      OP_STORE: begin
        ctrl.src_sel = RS1_IMM;
        ctrl.store   = 1'b1;
        imm          = imm_s;
      end
      OP_IMM: begin
        ctrl.src_sel   = RS1_IMM;
        ctrl.alu_op    = funct_to_alu(instr[14:12], instr[30], 1'b0);
        ctrl.reg_write = 1'b1;
      end
      OP_REG: begin
        ctrl.alu_op    = funct_to_alu(instr[14:12], instr[30], 1'b1);
        ctrl.reg_write = 1'b1;
      end
      // Anything else runs as a no-op.
      default: ;
    endcase
  end

endmodule

// File: hw/riscv_alu.sv
`include "riscv_settings.svh"

module riscv_alu import riscv_pkg::*; (
  input  alu_op_e             alu_op,
  input  logic [`RV_XLEN-1:0] a,
  input  logic [`RV_XLEN-1:0] b,
  output logic [`RV_XLEN-1:0] y,
  output logic                carry,
  output logic                overflow
);

  logic [`RV_XLEN:0] diff;
  logic [4:0]        shamt;

  // Borrow out of a - b.
  assign diff  = {1'b0, a} - {1'b0, b};
  assign carry = diff[`RV_XLEN];

  assign overflow = (a[`RV_XLEN-1] ^ b[`RV_XLEN-1]) & (a[`RV_XLEN-1] ^ diff[`RV_XLEN-1]);

  assign shamt = b[4:0];

  always_comb begin
    case (alu_op)
      ADD:     y = a + b;
      SUB:     y = diff[`RV_XLEN-1:0];
      SLL:     y = a << shamt;
      SLT:     y = `RV_XLEN'(diff[`RV_XLEN-1] ^ overflow);
      SLTU:    y = `RV_XLEN'(carry);
      XOR:     y = a ^ b;
      SRL:     y = a >> shamt;
      SRA:     y = $signed(a) >>> shamt;
      OR:      y = a | b;
      AND:     y = a & b;
      default: y = a + b;
    endcase
  end

endmodule

// File: hw/riscv_exu.sv
`include "riscv_settings.svh"

module riscv_exu import riscv_pkg::*; (
  input  logic [`RV_XLEN-1:0] pc,
  input  logic [`RV_XLEN-1:0] src1,
  input  logic [`RV_XLEN-1:0] src2,
  input  logic [`RV_XLEN-1:0] imm,
  input  ctrl_t               ctrl,
  output logic [`RV_XLEN-1:0] result,
  output logic [`RV_XLEN-1:0] next_pc
);

  logic [`RV_XLEN-1:0] alu_a;
  logic [`RV_XLEN-1:0] alu_b;
  logic [`RV_XLEN-1:0] alu_y;
  logic [`RV_XLEN-1:0] jalr_sum;
  logic                carry;
  logic                overflow;
  logic                zero;
  logic                less;
  logic                taken;

  always_comb begin
    case (ctrl.src_sel)
      RS1_RS2: begin
        alu_a = src1;
        alu_b = src2;
      end
      RS1_IMM: begin
        alu_a = src1;
        alu_b = imm;
      end
      PC_4: begin
        alu_a = pc;
        alu_b = `RV_XLEN'(4);
      end
      default: begin
        alu_a = pc;
        alu_b = imm;
      end
    endcase
  end

  riscv_alu i_riscv_alu (
    .alu_op   (ctrl.alu_op),
    .a        (alu_a),
    .b        (alu_b),
    .y        (alu_y),
    .carry    (carry),
    .overflow (overflow)
  );

  // Branches subtract rs2 from rs1.
  assign zero = (alu_y == '0);
  assign less = alu_y[`RV_XLEN-1] ^ overflow;

  always_comb begin
    case (ctrl.func3)
      3'b000:  taken = zero;
      3'b001:  taken = !zero;
      3'b100:  taken = less;
      3'b101:  taken = !less;
      3'b110:  taken = carry;
      3'b111:  taken = !carry;
      default: taken = 1'b0;
    endcase
  end

  assign jalr_sum = src1 + imm;

  always_comb begin
    if (ctrl.jalr) begin
      next_pc = {jalr_sum[`RV_XLEN-1:1], 1'b0};
    end else if (ctrl.jump || (ctrl.branch && taken)) begin
      next_pc = pc + imm;
    end else begin
      next_pc = pc + `RV_XLEN'(4);
    end
  end

  assign result = alu_y;

endmodule

// File: hw/riscv_regfile.sv
`include "riscv_settings.svh"

module riscv_regfile (
  input  logic                clk,
  input  logic                rst_n,
  input  logic [4:0]          rs1,
  input  logic [4:0]          rs2,
  input  logic [4:0]          rd,
  input  logic                we,
  input  logic [`RV_XLEN-1:0] wd,
  output logic [`RV_XLEN-1:0] rd1,
  output logic [`RV_XLEN-1:0] rd2
);

  logic [`RV_XLEN-1:0] regs [`RV_NREGS];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < `RV_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (rd != 5'd0)) begin
      regs[rd] <= wd;
    end
  end

  // x0 always reads zero.
  assign rd1 = (rs1 == 5'd0) ? '0 : regs[rs1];
  assign rd2 = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

// File: hw/riscv_core.sv
`include "riscv_settings.svh"

module riscv_core import riscv_pkg::*; (
  input  logic                clk,
  input  logic                rst_n,
  output wb_req_t             wb_req,
  input  logic [`RV_XLEN-1:0] wb_dat,
  input  logic                wb_ack
);

  core_state_e         state;
  logic [`RV_XLEN-1:0] pc;
  logic [`RV_XLEN-1:0] ir;
  logic                bus_act;
  logic                bus_we;
  logic [`RV_XLEN-1:0] bus_adr;
  logic [`RV_XLEN-1:0] bus_dat;
  ctrl_t               ctrl;
  logic [`RV_XLEN-1:0] imm;
  logic [`RV_XLEN-1:0] rd1;
  logic [`RV_XLEN-1:0] rd2;
  logic [`RV_XLEN-1:0] result;
  logic [`RV_XLEN-1:0] next_pc;
  logic                mem_op;
  logic                rf_we;
  logic [`RV_XLEN-1:0] rf_wd;

  riscv_decoder i_riscv_decoder (
    .instr (ir),
    .ctrl  (ctrl),
    .imm   (imm)
  );

  riscv_regfile i_riscv_regfile (
    .clk   (clk),
    .rst_n (rst_n),
    .rs1   (ctrl.rs1),
    .rs2   (ctrl.rs2),
    .rd    (ctrl.rd),
    .we    (rf_we),
    .wd    (rf_wd),
    .rd1   (rd1),
    .rd2   (rd2)
  );

  riscv_exu i_riscv_exu (
    .pc      (pc),
    .src1    (rd1),
    .src2    (rd2),
    .imm     (imm),
    .ctrl    (ctrl),
    .result  (result),
    .next_pc (next_pc)
  );

  assign mem_op = ctrl.load | ctrl.store;

  // Loads write back in the ack cycle of the data access.
  always_comb begin
    case (state)
      EXEC:    rf_we = ctrl.reg_write & ~ctrl.load;
      MEM:     rf_we = ctrl.reg_write & ctrl.load & wb_ack;
      default: rf_we = 1'b0;
    endcase
  end

  assign rf_wd = (state == MEM) ? wb_dat : result;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state   <= FETCH;
      pc      <= `RV_RESET_PC;
      bus_act <= 1'b0;
      bus_we  <= 1'b0;
    end else begin
      case (state)
        FETCH: begin
          if (!bus_act) begin
            bus_act <= 1'b1;
            bus_we  <= 1'b0;
          end else if (wb_ack) begin
            bus_act <= 1'b0;
            state   <= EXEC;
          end
        end
        EXEC: begin
          bus_act <= 1'b1;
          if (mem_op) begin
            bus_we <= ctrl.store;
            state  <= MEM;
          end else begin
            // Next fetch starts straight away.
            bus_we <= 1'b0;
            pc     <= next_pc;
            state  <= FETCH;
          end
        end
        default: begin
          if (wb_ack) begin
            bus_act <= 1'b0;
            bus_we  <= 1'b0;
            pc      <= next_pc;
            state   <= FETCH;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    case (state)
      FETCH: begin
        if (!bus_act) begin
          bus_adr <= pc;
        end else if (wb_ack) begin
          ir <= wb_dat;
        end
      end
      EXEC: begin
        if (mem_op) begin
          bus_adr <= result;
          bus_dat <= rd2;
        end else begin
          bus_adr <= next_pc;
        end
      end
      default: ;
    endcase
  end

  always_comb begin
    wb_req.cyc = bus_act;
    wb_req.stb = bus_act;
    wb_req.we  = bus_we;
    wb_req.sel = 4'hf;
    wb_req.adr = bus_adr;
    wb_req.dat = bus_dat;
  end

endmodule

// File: verification/riscv_core_props.sv
`include "riscv_settings.svh"

module riscv_core_props import riscv_pkg::*; (
  input logic    clk,
  input logic    rst_n,
  input wb_req_t wb_req,
  input logic    wb_ack
);

  // Strobe is only valid inside a cycle.
  stb_in_cyc: assert property (@(posedge clk) disable iff (!rst_n)
    wb_req.stb |-> wb_req.cyc)
    else $error("stb high while cyc is low");

  // Request must hold until the slave acknowledges it.
  req_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (wb_req.stb && !wb_ack) |=> (wb_req.stb && $stable(wb_req.adr) && $stable(wb_req.we)
                                 && (!wb_req.we || $stable(wb_req.dat))))
    else $error("request changed before ack");

  reset_idle: assert property (@(posedge clk) $rose(rst_n) |-> !wb_req.cyc)
    else $error("cyc high in the first cycle after reset");

endmodule

bind riscv_core riscv_core_props i_riscv_core_props (
  .clk    (clk),
  .rst_n  (rst_n),
  .wb_req (wb_req),
  .wb_ack (wb_ack)
);

// File: verification/riscv_core_tb.sv
`include "riscv_settings.svh"

module riscv_core_tb import riscv_pkg::*; ();

  localparam int WAIT_LIMIT = 20000;

  logic                clk;
  logic                rst_n;
  wb_req_t             wb_req;
  logic [`RV_XLEN-1:0] wb_dat;
  logic                wb_ack;

  logic [31:0] mem [512];
  logic [31:0] mem_ref [512];
  logic [31:0] prog [$];
  logic [31:0] exp_adr [$];
  logic [31:0] exp_val [$];
  logic [31:0] rand_state;
  logic        rand_mode;
  logic        pending;
  logic [1:0]  wait_cnt;
  logic        done;
  int          errors;

  riscv_core i_riscv_core (
    .clk    (clk),
    .rst_n  (rst_n),
    .wb_req (wb_req),
    .wb_dat (wb_dat),
    .wb_ack (wb_ack)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] fill_word(input logic [31:0] adr);
    return 32'ha5a5_0000 ^ adr;
  endfunction

  function automatic logic [31:0] as_word(input logic c);
    return {31'b0, c};
  endfunction

  // Bus slave that may wait a random number of cycles before each ack.
  always @(negedge clk) begin
    if (!rst_n) begin
      wb_ack  = 1'b0;
      pending = 1'b0;
    end else if (wb_ack) begin
      wb_ack  = 1'b0;
      pending = 1'b0;
    end else if (wb_req.cyc && wb_req.stb) begin
      if (!pending) begin
        pending    = 1'b1;
        rand_state = xorshift(rand_state);
        wait_cnt   = rand_mode ? rand_state[1:0] : 2'd0;
      end
      if (wait_cnt == 2'd0) begin
        if (wb_req.we) begin
          mem[wb_req.adr[10:2]] = wb_req.dat;
          if (wb_req.adr == `RV_DONE_ADDR) begin
            done = 1'b1;
          end
        end else begin
          wb_dat = mem[wb_req.adr[10:2]];
        end
        wb_ack = 1'b1;
      end else begin
        wait_cnt = wait_cnt - 2'd1;
      end
    end
  end

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                        input logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
  endfunction

  function automatic logic branch_rule(input logic [2:0] f3, input logic [31:0] a,
                                       input logic [31:0] b);
    case (f3)
      3'b000:  return a == b;
      3'b001:  return a != b;
      3'b100:  return $signed(a) < $signed(b);
      3'b101:  return $signed(a) >= $signed(b);
      3'b110:  return a < b;
      default: return a >= b;
    endcase
  endfunction

  task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      errors++;
      $display("Mismatch %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  // An idle request only defines cyc, stb and we.
  task automatic check_bus(input string name, input wb_req_t exp, input wb_req_t act);
    logic ok;
    ok = (exp.cyc === act.cyc) && (exp.stb === act.stb) && (exp.we === act.we);
    if (exp.cyc) begin
      ok = ok && (exp.sel === act.sel) && (exp.adr === act.adr);
    end
    if (exp.we) begin
      ok = ok && (exp.dat === act.dat);
    end
    if (!ok) begin
      errors++;
      $display("Mismatch %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic emit(input logic [31:0] word);
    prog.push_back(word);
  endtask

  task automatic expect_word(input logic [31:0] adr, input logic [31:0] val);
    exp_adr.push_back(adr);
    exp_val.push_back(val);
  endtask

  // Each result goes to its own word from 0x400 upwards.
  task automatic store_result(input logic [4:0] rs, input logic [31:0] val);
    logic [31:0] adr;
    adr = 32'h400 + 32'(exp_adr.size()) * 32'd4;
    emit(enc_s(adr[11:0], rs, 5'd0));
    expect_word(adr, val);
  endtask

  task automatic emit_li(input logic [4:0] rd, input logic [31:0] v);
    logic [31:0] hi;
    hi = v + 32'h800;
    emit(enc_u(hi[31:12], rd, OP_LUI));
    emit(enc_i(v[11:0], rd, 3'b000, rd, OP_IMM));
  endtask

  task automatic op_check(input logic [31:0] instr, input logic [31:0] val);
    emit(instr);
    store_result(5'd5, val);
  endtask

  task automatic clear_program();
    prog.delete();
    exp_adr.delete();
    exp_val.delete();
  endtask

  task automatic load_memory();
    for (int i = 0; i < 512; i++) begin
      mem[i] = fill_word(32'(i) << 2);
    end
    // Done store, then spin in place.
    prog.push_back(enc_s(12'(`RV_DONE_ADDR), 5'd0, 5'd0));
    prog.push_back(enc_j(21'd0, 5'd0));
    for (int i = 0; i < prog.size(); i++) begin
      mem[i] = prog[i];
    end
    void'(prog.pop_back());
    void'(prog.pop_back());
  endtask

  task automatic apply_reset(input logic check);
    wb_req_t idle;
    idle  = '0;
    done  = 1'b0;
    rst_n = 1'b0;
    repeat (3) begin
      @(negedge clk);
      if (check) begin
        check_bus("reset", idle, wb_req);
      end
    end
    rst_n = 1'b1;
    if (check) begin
      check_bus("reset release", idle, wb_req);
    end
  endtask

  task automatic run_program(input string name, input logic rnd);
    int cnt;
    rand_mode = rnd;
    load_memory();
    apply_reset(1'b0);
    cnt = 0;
    while (!done && cnt < WAIT_LIMIT) begin
      @(negedge clk);
      cnt++;
    end
    if (!done) begin
      errors++;
      $display("%s: program never finished, no store reached the done address", name);
    end else begin
      for (int i = 0; i < exp_adr.size(); i++) begin
        check_word(name, exp_val[i], mem[exp_adr[i][10:2]]);
      end
    end
  endtask

  task automatic test_reset();
    wb_req_t first;
    int      cnt;
    first     = '0;
    first.cyc = 1'b1;
    first.stb = 1'b1;
    first.sel = 4'hf;
    first.adr = `RV_RESET_PC;
    clear_program();
    rand_mode = 1'b0;
    load_memory();
    apply_reset(1'b1);
    cnt = 0;
    while (!wb_req.stb && cnt < WAIT_LIMIT) begin
      @(negedge clk);
      cnt++;
    end
    if (!wb_req.stb) begin
      errors++;
      $display("reset: core never started a bus request");
    end else begin
      check_bus("first fetch", first, wb_req);
    end
  endtask

  task automatic build_arith();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    logic [31:0] pc_now;
    a = 32'h8000_0000;
    b = 32'hffff_ffff;
    c = 32'd7;
    emit_li(5'd1, a);
    emit_li(5'd2, b);
    emit_li(5'd3, 32'd31);
    emit_li(5'd4, c);
    op_check(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd5), a + b);
    op_check(enc_r(7'h20, 5'd1, 5'd4, 3'b000, 5'd5), c - a);
    op_check(enc_r(7'h00, 5'd3, 5'd2, 3'b001, 5'd5), b << 31);
    op_check(enc_r(7'h00, 5'd4, 5'd1, 3'b010, 5'd5), as_word($signed(a) < $signed(c)));
    op_check(enc_r(7'h00, 5'd4, 5'd1, 3'b011, 5'd5), as_word(a < c));
    op_check(enc_r(7'h00, 5'd2, 5'd1, 3'b100, 5'd5), a ^ b);
    op_check(enc_r(7'h00, 5'd3, 5'd1, 3'b101, 5'd5), a >> 31);
    op_check(enc_r(7'h20, 5'd3, 5'd1, 3'b101, 5'd5), 32'($signed(a) >>> 31));
    op_check(enc_r(7'h00, 5'd4, 5'd1, 3'b110, 5'd5), a | c);
    op_check(enc_r(7'h00, 5'd4, 5'd2, 3'b111, 5'd5), b & c);
    op_check(enc_i(12'hfff, 5'd1, 3'b000, 5'd5, OP_IMM), a - 32'd1);
    op_check(enc_i(12'h000, 5'd2, 3'b010, 5'd5, OP_IMM), as_word($signed(b) < 0));
    op_check(enc_i(12'hfff, 5'd2, 3'b011, 5'd5, OP_IMM), as_word(b < 32'hffff_ffff));
    op_check(enc_i({7'h20, 5'd31}, 5'd1, 3'b101, 5'd5, OP_IMM), 32'($signed(a) >>> 31));
    op_check(enc_i({7'h00, 5'd31}, 5'd4, 3'b001, 5'd5, OP_IMM), c << 31);
    op_check(enc_i({7'h00, 5'd31}, 5'd2, 3'b101, 5'd5, OP_IMM), b >> 31);
    op_check(enc_i(12'h555, 5'd2, 3'b100, 5'd5, OP_IMM), b ^ 32'h555);
    op_check(enc_u(20'habcde, 5'd5, OP_LUI), 32'habcd_e000);
    pc_now = 32'(prog.size()) << 2;
    op_check(enc_u(20'h00012, 5'd5, OP_AUIPC), pc_now + 32'h12000);
  endtask

  task automatic build_branch();
    logic [31:0] pa [3];
    logic [31:0] pb [3];
    logic [2:0]  f3s [6];
    pa  = '{32'd5, 32'hffff_ffff, 32'd1};
    pb  = '{32'd5, 32'd1, 32'hffff_ffff};
    f3s = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
    for (int p = 0; p < 3; p++) begin
      emit_li(5'd1, pa[p]);
      emit_li(5'd2, pb[p]);
      for (int k = 0; k < 6; k++) begin
        // Marker stays 1 only when the branch skips the clear.
        emit(enc_i(12'd1, 5'd0, 3'b000, 5'd5, OP_IMM));
        emit(enc_b(13'd8, 5'd2, 5'd1, f3s[k]));
        emit(enc_i(12'd0, 5'd0, 3'b000, 5'd5, OP_IMM));
        store_result(5'd5, as_word(branch_rule(f3s[k], pa[p], pb[p])));
      end
    end
  endtask

  task automatic build_jump();
    logic [31:0] pc_now;
    emit(enc_i(12'd0, 5'd0, 3'b000, 5'd7, OP_IMM));
    pc_now = 32'(prog.size()) << 2;
    emit(enc_j(21'd12, 5'd6));
    emit(enc_i(12'd1, 5'd0, 3'b000, 5'd7, OP_IMM));
    emit(enc_i(12'd1, 5'd0, 3'b000, 5'd7, OP_IMM));
    store_result(5'd6, pc_now + 32'd4);
    store_result(5'd7, 32'd0);
    // The target sum is odd and bit 0 must be cleared.
    pc_now = 32'(prog.size()) << 2;
    emit(enc_u(20'd0, 5'd8, OP_AUIPC));
    emit(enc_i(12'd17, 5'd8, 3'b000, 5'd9, OP_JALR));
    emit(enc_i(12'd1, 5'd0, 3'b000, 5'd7, OP_IMM));
    emit(enc_i(12'd1, 5'd0, 3'b000, 5'd7, OP_IMM));
    // Landing address as seen by the core.
    emit(enc_u(20'd0, 5'd10, OP_AUIPC));
    store_result(5'd9, pc_now + 32'd8);
    store_result(5'd7, 32'd0);
    store_result(5'd10, pc_now + 32'd16);
  endtask

  task automatic test_arith();
    clear_program();
    build_arith();
    run_program("arith", 1'b0);
  endtask

  task automatic test_branch();
    clear_program();
    build_branch();
    run_program("branch", 1'b0);
  endtask

  task automatic test_jump();
    clear_program();
    build_jump();
    run_program("jump", 1'b0);
  endtask

  task automatic test_load_store();
    clear_program();
    emit_li(5'd1, 32'h1234_5678);
    emit(enc_s(12'h300, 5'd1, 5'd0));
    expect_word(32'h300, 32'h1234_5678);
    emit(enc_i(12'h300, 5'd0, 3'b010, 5'd10, OP_LOAD));
    store_result(5'd10, 32'h1234_5678);
    emit(enc_i(12'h380, 5'd0, 3'b010, 5'd11, OP_LOAD));
    store_result(5'd11, fill_word(32'h380));
    emit(enc_i(12'h300, 5'd0, 3'b010, 5'd0, OP_LOAD));
    emit(enc_i(12'd5, 5'd0, 3'b000, 5'd0, OP_IMM));
    store_result(5'd0, 32'd0);
    run_program("load_store", 1'b0);
  endtask

  task automatic test_back_pressure();
    clear_program();
    build_arith();
    build_branch();
    build_jump();
    run_program("bp_fixed", 1'b0);
    for (int i = 0; i < 512; i++) begin
      mem_ref[i] = mem[i];
    end
    run_program("bp_random", 1'b1);
    for (int i = 0; i < 512; i++) begin
      check_word("bp_memory", mem_ref[i], mem[i]);
    end
  endtask

  initial begin
    rst_n      = 1'b0;
    wb_dat     = '0;
    wb_ack     = 1'b0;
    pending    = 1'b0;
    wait_cnt   = 2'd0;
    done       = 1'b0;
    rand_mode  = 1'b0;
    rand_state = 32'hd312;
    errors     = 0;
    test_reset();
    test_arith();
    test_branch();
    test_jump();
    test_load_store();
    test_back_pressure();
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: list.f
+incdir+hw
hw/riscv_pkg.sv
hw/riscv_decoder.sv
hw/riscv_alu.sv
hw/riscv_exu.sv
hw/riscv_regfile.sv
hw/riscv_core.sv
verification/riscv_core_props.sv
verification/riscv_core_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module riscv_core_tb \
  -o riscv_core_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/riscv_core_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "TEST FAILED" sim.log; then
  exit 1
fi
grep -q "TEST OK" sim.log || exit 1
exit 0
